// ==== icb_unalign_bridge.f ====
design/icb_pkg.sv
design/align_pkg.sv
design/cmd_queue.sv
design/bridge_ctrl.sv
design/wdata_realign.sv
design/rdata_realign.sv
design/icb_unalign_bridge.sv
tests/bridge_assertions.sv
tests/tb_icb_unalign_bridge.sv

// ==== Makefile ====
# Verilator build and run of the bridge testbench

TOP := tb_icb_unalign_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f icb_unalign_bridge.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== tests/tb_icb_unalign_bridge.sv ====
// directed testbench for the unaligned ICB bridge
// byte memory responder downstream, burst tasks upstream, summary at the end

`timescale 1ns/100ps

module tb_icb_unalign_bridge;
  import icb_pkg::*;

  localparam int q_depth     = 4;
  localparam int rsp_lat     = 2;
  localparam int mem_size    = 4096;
  localparam int cycle_limit = 20000;

  logic        clk;
  logic        rst_n;
  logic        sa_cmd_valid;
  icb_cmd_t    sa_cmd;
  logic        sa_cmd_ready;
  logic        sa_w_valid;
  icb_wbeat_t  sa_w;
  logic        sa_w_ready;
  logic        sa_rsp_valid;
  icb_rsp_t    sa_rsp;
  logic        sa_rsp_ready;
  logic        m_cmd_valid;
  icb_mcmd_t   m_cmd;
  logic        m_cmd_ready;
  logic        m_rsp_valid;
  icb_rsp_t    m_rsp;
  logic        m_rsp_ready;

  // downstream memory and the expected image
  logic [7:0]  mem [mem_size];
  logic [7:0]  exp_mem [mem_size];
  logic [31:0] rdata_q [$];
  logic        rerr_q [$];
  int          due_q [$];
  int          cycles;
  int          dn_beats;
  int          rsp_errs;
  int          mem_errs;
  int          cnt_errs;
  int          asrt_errs;
  logic [31:0] rng_state;
  bit          stall_en;
  bit          hold_cmd;
  bit          err_en;
  logic [9:0]  err_word;

  icb_unalign_bridge #(
    .outs_depth (q_depth)
  ) u_icb_unalign_bridge (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================
  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // ready about three cycles in four
  function bit rand_ready();
    logic [31:0] v;
    v = next_rand();
    return v[20:19] != 2'b00;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 13) ^ (a >> 8) ^ 8'h5a);
  endfunction

  // marked word answers with err
  function automatic bit word_err(input logic [31:0] a);
    return err_en && (a[11:2] == err_word);
  endfunction

  // ========================================
  // downstream responder
  // ========================================
  always @(posedge clk) begin : responder
    int          wa;
    logic [31:0] rd;
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end else begin
      if (rst_n && m_cmd_valid && m_cmd_ready) begin
        dn_beats++;
        wa = int'(m_cmd.addr[11:0]);
        if (!m_cmd.read) begin
          for (int i = 0; i < 4; i++) begin
            if (m_cmd.wmask[i]) mem[wa+i] = m_cmd.wdata[8*i +: 8];
          end
        end
        rd = {mem[wa+3], mem[wa+2], mem[wa+1], mem[wa]};
        rdata_q.push_back(rd);
        rerr_q.push_back(word_err(m_cmd.addr));
        due_q.push_back(cycles + rsp_lat);
      end
      if (rst_n && m_rsp_valid && m_rsp_ready) begin
        void'(rdata_q.pop_front());
        void'(rerr_q.pop_front());
        void'(due_q.pop_front());
      end
      #1;
      // head of queue stays valid until taken
      if (due_q.size() > 0 && due_q[0] <= cycles) begin
        m_rsp_valid = 1'b1;
        m_rsp.rdata = rdata_q[0];
        m_rsp.err   = rerr_q[0];
      end else begin
        m_rsp_valid = 1'b0;
      end
      m_cmd_ready = hold_cmd ? 1'b0 : (stall_en ? rand_ready() : 1'b1);
    end
  end

  // ========================================
  // compare tasks
  // ========================================
  task automatic check_rsp(input icb_rsp_t got, input icb_rsp_t exp, input bit data_chk,
                           input string what);
    if (data_chk && got.rdata !== exp.rdata) begin
      rsp_errs++;
      $display("ERR %0t: %s rdata got %h exp %h", $time, what, got.rdata, exp.rdata);
    end
    if (got.err !== exp.err) begin
      rsp_errs++;
      $display("ERR %0t: %s err got %b exp %b", $time, what, got.err, exp.err);
    end
  endtask

  task automatic check_bytes(input int start, input int n, input string what);
    for (int k = start; k < start + n; k++) begin
      if (mem[k] !== exp_mem[k]) begin
        mem_errs++;
        $display("ERR %0t: %s byte %h got %h exp %h", $time, what, k, mem[k], exp_mem[k]);
      end
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      cnt_errs++;
      $display("ERR %0t: %s got %0d exp %0d", $time, what, got, exp);
    end
  endtask

  // ========================================
  // upstream drivers
  // ========================================
  task automatic send_cmd(input logic [31:0] addr, input bit rd, input int len);
    sa_cmd_valid = 1'b1;
    sa_cmd.addr  = addr;
    sa_cmd.read  = rd;
    sa_cmd.len   = 3'(len);
    do @(posedge clk); while (!sa_cmd_ready);
    #1;
    sa_cmd_valid = 1'b0;
  endtask

  task automatic send_wbeat(input logic [31:0] data, input logic [3:0] mask);
    sa_w_valid = 1'b1;
    sa_w.wdata = data;
    sa_w.wmask = mask;
    do @(posedge clk); while (!sa_w_ready);
    #1;
    sa_w_valid = 1'b0;
  endtask

  task automatic get_rsp(output icb_rsp_t r);
    bit got;
    got = 1'b0;
    while (!got) begin
      sa_rsp_ready = stall_en ? rand_ready() : 1'b1;
      @(posedge clk);
      if (sa_rsp_valid && sa_rsp_ready) begin
        r   = sa_rsp;
        got = 1'b1;
      end
      #1;
    end
    sa_rsp_ready = 1'b0;
  endtask

  // bytes addr .. addr+4(len+1)-1 written, one response expected
  task automatic write_burst(input logic [31:0] addr, input int len, input bit full_mask);
    logic [31:0] data;
    logic [31:0] r32;
    logic [3:0]  mask;
    icb_rsp_t    r;
    icb_rsp_t    exp;
    int          base;
    base     = int'(addr);
    dn_beats = 0;
    exp      = '0;
    for (int w = base & ~3; w < base + 4 * (len + 1); w += 4) begin
      exp.err = exp.err | word_err(32'(w));
    end
    send_cmd(addr, 1'b0, len);
    for (int b = 0; b <= len; b++) begin
      data = next_rand();
      r32  = next_rand();
      mask = full_mask ? 4'hf : r32[11:8];
      for (int i = 0; i < 4; i++) begin
        if (mask[i]) exp_mem[base + 4*b + i] = data[8*i +: 8];
      end
      send_wbeat(data, mask);
    end
    get_rsp(r);
    check_rsp(r, exp, 1'b0, "write rsp");
    @(posedge clk);
    if (sa_rsp_valid) begin
      cnt_errs++;
      $display("an extra write response appeared after the burst at %0t", $time);
    end
    #1;
    check_count(dn_beats, len + 1 + int'(addr[1:0] != 2'b00), "write beats");
    check_bytes((base & ~3) - 4, 4 * (len + 4), "write mem");
  endtask

  task automatic read_burst(input logic [31:0] addr, input int len);
    icb_rsp_t r;
    icb_rsp_t exp;
    int       a;
    dn_beats = 0;
    send_cmd(addr, 1'b1, len);
    for (int j = 0; j <= len; j++) begin
      a         = int'(addr) + 4 * j;
      exp.rdata = {exp_mem[a+3], exp_mem[a+2], exp_mem[a+1], exp_mem[a]};
      // spans one word or two
      exp.err   = word_err(32'(a)) | word_err(32'(a + 3));
      get_rsp(r);
      check_rsp(r, exp, 1'b1, "read rsp");
    end
    check_count(dn_beats, len + 1 + int'(addr[1:0] != 2'b00), "read beats");
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic aligned_bursts();
    for (int len = 0; len < 8; len++) begin
      write_burst(32'h100 + 32'(len * 64), len, 1'b1);
      read_burst(32'h100 + 32'(len * 64), len);
    end
  endtask

  task automatic unaligned_writes();
    logic [31:0] v;
    for (int off = 1; off < 4; off++) begin
      for (int rep = 0; rep < 2; rep++) begin
        v = next_rand();
        write_burst(32'h400 + 32'(off + (off * 2 + rep) * 64), int'(v[2:0]), 1'b0);
      end
    end
  endtask

  task automatic unaligned_reads();
    logic [31:0] v;
    for (int off = 1; off < 4; off++) begin
      v = next_rand();
      read_burst(32'h600 + 32'(off + off * 64), int'(v[2:0]));
    end
  endtask

  task automatic stalled_bursts();
    logic [31:0] v;
    stall_en = 1'b1;
    for (int off = 0; off < 4; off++) begin
      v = next_rand();
      write_burst(32'h800 + 32'(off + off * 64), int'(v[2:0]), 1'b0);
      read_burst(32'h800 + 32'(off + off * 64), int'(v[2:0]));
    end
    stall_en = 1'b0;
  endtask

  task automatic queue_fill();
    logic [31:0] addrs [q_depth+1];
    icb_rsp_t    r;
    icb_rsp_t    exp;
    int          a;
    hold_cmd = 1'b1;
    @(posedge clk);
    #1;
    // one held by the controller, the rest fill the queue
    for (int i = 0; i <= q_depth; i++) begin
      addrs[i] = 32'hA00 + 32'(8 * i + i % 4);
      send_cmd(addrs[i], 1'b1, 0);
    end
    check_count(int'(sa_cmd_ready), 0, "cmd ready with queue full");
    hold_cmd = 1'b0;
    for (int i = 0; i <= q_depth; i++) begin
      a         = int'(addrs[i]);
      exp.rdata = {exp_mem[a+3], exp_mem[a+2], exp_mem[a+1], exp_mem[a]};
      exp.err   = 1'b0;
      get_rsp(r);
      check_rsp(r, exp, 1'b1, "queued read");
    end
  endtask

  task automatic error_forwarding();
    err_en   = 1'b1;
    err_word = 10'(32'hC44 >> 2);
    read_burst(32'hC39, 3);
    read_burst(32'hC40, 2);
    write_burst(32'hC42, 1, 1'b1);
    write_burst(32'hC00, 1, 1'b1);
    err_en = 1'b0;
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    rng_state    = 32'd9;
    cycles       = 0;
    dn_beats     = 0;
    rsp_errs     = 0;
    mem_errs     = 0;
    cnt_errs     = 0;
    asrt_errs    = 0;
    stall_en     = 1'b0;
    hold_cmd     = 1'b0;
    err_en       = 1'b0;
    err_word     = '0;
    rst_n        = 1'b0;
    sa_cmd_valid = 1'b0;
    sa_cmd       = '0;
    sa_w_valid   = 1'b0;
    sa_w         = '0;
    sa_rsp_ready = 1'b0;
    m_cmd_ready  = 1'b0;
    m_rsp_valid  = 1'b0;
    m_rsp        = '0;
    for (int k = 0; k < mem_size; k++) begin
      mem[k]     = fill_byte(k);
      exp_mem[k] = fill_byte(k);
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    aligned_bursts();
    unaligned_writes();
    unaligned_reads();
    stalled_bursts();
    queue_fill();
    error_forwarding();
    repeat (4) @(posedge clk);
    asrt_errs = u_icb_unalign_bridge.u_bridge_assertions.fail_cnt;
    $display("summary: %0d rsp, %0d mem, %0d count, %0d assertion errors",
             rsp_errs, mem_errs, cnt_errs, asrt_errs);
    if (rsp_errs + mem_errs + cnt_errs + asrt_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tests/bridge_assertions.sv ====
// protocol checks on both ports of the bridge
// attached to every bridge instance through the bind at the end of the file

`timescale 1ns/100ps

module bridge_assertions (
  input logic                clk,
  input logic                rst_n,
  input logic                m_cmd_valid,
  input icb_pkg::icb_mcmd_t  m_cmd,
  input logic                m_cmd_ready,
  input logic                sa_rsp_valid,
  input icb_pkg::icb_rsp_t   sa_rsp,
  input logic                sa_rsp_ready,
  input logic                sa_w_ready
);
  import icb_pkg::*;

  // failed assertion count
  int fail_cnt = 0;

  // downstream only ever sees word addresses
  a_cmd_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    m_cmd_valid |-> (m_cmd.addr[1:0] == 2'b00))
    else begin
      fail_cnt++;
      $error("downstream command address not word aligned");
    end

  // payload held while stalled
  a_cmd_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (m_cmd_valid && !m_cmd_ready) |=> (m_cmd_valid && $stable(m_cmd)))
    else begin
      fail_cnt++;
      $error("downstream command changed while stalled");
    end

  a_rsp_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (sa_rsp_valid && !sa_rsp_ready) |=> (sa_rsp_valid && $stable(sa_rsp)))
    else begin
      fail_cnt++;
      $error("upstream response changed while stalled");
    end

  // write beats move only with their downstream beat
  a_w_gated : assert property (@(posedge clk) disable iff (!rst_n)
    sa_w_ready |-> m_cmd_ready)
    else begin
      fail_cnt++;
      $error("write ready high while downstream command stalled");
    end

endmodule

bind icb_unalign_bridge bridge_assertions u_bridge_assertions (.*);

// ==== design/icb_unalign_bridge.sv ====
// unaligned-to-aligned ICB bridge top, byte-addressed slave port in,
// word-aligned master port out

`timescale 1ns/100ps

module icb_unalign_bridge #(
  parameter int outs_depth = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  // upstream slave port
  input  logic                sa_cmd_valid,
  input  icb_pkg::icb_cmd_t   sa_cmd,
  output logic                sa_cmd_ready,
  input  logic                sa_w_valid,
  input  icb_pkg::icb_wbeat_t sa_w,
  output logic                sa_w_ready,
  output logic                sa_rsp_valid,
  output icb_pkg::icb_rsp_t   sa_rsp,
  input  logic                sa_rsp_ready,
  // downstream master port
  output logic                m_cmd_valid,
  output icb_pkg::icb_mcmd_t  m_cmd,
  input  logic                m_cmd_ready,
  input  logic                m_rsp_valid,
  input  icb_pkg::icb_rsp_t   m_rsp,
  output logic                m_rsp_ready
);
  import icb_pkg::*;
  import align_pkg::*;

  logic               q_push;
  logic               q_pop;
  logic               q_full;
  logic               q_empty;
  icb_cmd_t           q_head;
  req_rec_t           cur;
  beat_cnt_t          cmd_beat;
  beat_cnt_t          rsp_beat;
  logic               w_take;
  logic               cmd_fire;
  logic               rsp_fire;
  logic               emit;
  logic [addr_w-1:0]  m_addr;
  logic [data_w-1:0]  m_wdata;
  logic [bytes_w-1:0] m_wmask;

  // ========================================
  // upstream command into the queue
  // ========================================
  assign sa_cmd_ready = !q_full;
  assign q_push       = sa_cmd_valid && sa_cmd_ready;

  cmd_queue #(
    .outs_depth (outs_depth)
  ) u_cmd_queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (q_push),
    .push_cmd (sa_cmd),
    .pop      (q_pop),
    .head     (q_head),
    .full     (q_full),
    .empty    (q_empty)
  );

  bridge_ctrl u_bridge_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .q_empty      (q_empty),
    .q_head       (q_head),
    .q_pop        (q_pop),
    .sa_w_valid   (sa_w_valid),
    .sa_w_ready   (sa_w_ready),
    .m_cmd_ready  (m_cmd_ready),
    .m_cmd_valid  (m_cmd_valid),
    .m_addr       (m_addr),
    .m_rsp_valid  (m_rsp_valid),
    .emit         (emit),
    .sa_rsp_ready (sa_rsp_ready),
    .m_rsp_ready  (m_rsp_ready),
    .sa_rsp_valid (sa_rsp_valid),
    .cur          (cur),
    .cmd_beat     (cmd_beat),
    .rsp_beat     (rsp_beat),
    .w_take       (w_take),
    .cmd_fire     (cmd_fire),
    .rsp_fire     (rsp_fire)
  );

  // ========================================
  // data paths
  // ========================================
  wdata_realign u_wdata_realign (
    .clk      (clk),
    .rst_n    (rst_n),
    .cur      (cur),
    .cmd_beat (cmd_beat),
    .w_take   (w_take),
    .cmd_fire (cmd_fire),
    .sa_w     (sa_w),
    .m_wdata  (m_wdata),
    .m_wmask  (m_wmask)
  );

  rdata_realign u_rdata_realign (
    .clk      (clk),
    .rst_n    (rst_n),
    .cur      (cur),
    .rsp_fire (rsp_fire),
    .rsp_beat (rsp_beat),
    .m_rsp    (m_rsp),
    .rsp_out  (sa_rsp),
    .emit     (emit)
  );

  // downstream command payload
  assign m_cmd.addr  = m_addr;
  assign m_cmd.read  = cur.read;
  assign m_cmd.wdata = m_wdata;
  assign m_cmd.wmask = m_wmask;

endmodule

// ==== design/rdata_realign.sv ====
// response builder: joins pairs of downstream read words into upstream beats
// and folds downstream write errors into the single write response

`timescale 1ns/100ps

module rdata_realign (
  input  logic                   clk,
  input  logic                   rst_n,
  input  align_pkg::req_rec_t    cur,
  input  logic                   rsp_fire,
  input  align_pkg::beat_cnt_t   rsp_beat,
  input  icb_pkg::icb_rsp_t      m_rsp,
  output icb_pkg::icb_rsp_t      rsp_out,
  output logic                   emit
);
  import icb_pkg::*;
  import align_pkg::*;

  offset_t             off;
  logic                is_last;
  // previous read word, payload only
  logic [data_w-1:0]   hold_data;
  // previous read err, or running write err
  logic                err_q;
  logic [2*data_w-1:0] pair;

  assign off     = cur.addr.w.off;
  assign is_last = (rsp_beat == last_beat(cur));

  // word j in the low half, word j+1 above, shift the offset out
  assign pair = {m_rsp.rdata, hold_data} >> {off, 3'b000};

  // ========================================
  // output select
  // ========================================
  always_comb begin
    rsp_out = '0;
    emit    = 1'b0;
    if (cur.read) begin
      if (cur.crosses) begin
        // first word only primes the holding register
        emit          = (rsp_beat != '0);
        rsp_out.rdata = pair[data_w-1:0];
        rsp_out.err   = err_q | m_rsp.err;
      end else begin
        emit    = 1'b1;
        rsp_out = m_rsp;
      end
    end else begin
      // one write response per request
      emit        = is_last;
      rsp_out.err = err_q | m_rsp.err;
    end
  end

  // ========================================
  // holding registers
  // ========================================
  always_ff @(posedge clk) begin
    if (rsp_fire && cur.read) begin
      hold_data <= m_rsp.rdata;
    end
  end

  // cleared on the last beat so the next burst starts clean
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (rsp_fire) begin
      if (is_last) begin
        err_q <= 1'b0;
      end else if (cur.read) begin
        err_q <= m_rsp.err;
      end else begin
        err_q <= err_q | m_rsp.err;
      end
    end
  end

endmodule

// ==== design/wdata_realign.sv ====
// write lane shifter: moves upstream bytes to their downstream lanes and
// carries the spilled high bytes into the following beat

`timescale 1ns/100ps

module wdata_realign (
  input  logic                          clk,
  input  logic                          rst_n,
  input  align_pkg::req_rec_t           cur,
  input  align_pkg::beat_cnt_t          cmd_beat,
  input  logic                          w_take,
  input  logic                          cmd_fire,
  input  icb_pkg::icb_wbeat_t           sa_w,
  output logic [icb_pkg::data_w-1:0]    m_wdata,
  output logic [icb_pkg::bytes_w-1:0]   m_wmask
);
  import icb_pkg::*;
  import align_pkg::*;

  offset_t              off;
  logic                 has_w;
  // low half goes out now, high half spills
  logic [2*data_w-1:0]  data_wide;
  logic [2*bytes_w-1:0] mask_wide;
  logic [data_w-1:0]    carry_data;
  logic [bytes_w-1:0]   carry_mask;

  assign off   = cur.addr.w.off;
  // final unaligned beat has no upstream term
  assign has_w = w_beat_needed(cur, cmd_beat);

  // ========================================
  // lane shift
  // ========================================
  assign data_wide = {{data_w{1'b0}}, sa_w.wdata} << {off, 3'b000};
  assign mask_wide = {{bytes_w{1'b0}}, sa_w.wmask} << off;

  // current beat low part plus spill of the previous beat
  assign m_wdata = (has_w ? data_wide[data_w-1:0] : '0) | carry_data;
  assign m_wmask = (has_w ? mask_wide[bytes_w-1:0] : '0) | carry_mask;

  // ========================================
  // carry buffer
  // ========================================
  // aligned bursts load zero spill, extra beat empties the buffer,
  // so every burst starts clean
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_data <= '0;
      carry_mask <= '0;
    end else if (w_take) begin
      carry_data <= data_wide[2*data_w-1:data_w];
      carry_mask <= mask_wide[2*bytes_w-1:bytes_w];
    end else if (cmd_fire) begin
      carry_data <= '0;
      carry_mask <= '0;
    end
  end

endmodule

// ==== design/bridge_ctrl.sv ====
// request sequencer: pops one queued request, issues its aligned beats, then
// waits for the last response before taking the next one

`timescale 1ns/100ps

module bridge_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  // queue side
  input  logic                         q_empty,
  input  icb_pkg::icb_cmd_t            q_head,
  output logic                         q_pop,
  // upstream write channel gating
  input  logic                         sa_w_valid,
  output logic                         sa_w_ready,
  // downstream command
  input  logic                         m_cmd_ready,
  output logic                         m_cmd_valid,
  output logic [icb_pkg::addr_w-1:0]   m_addr,
  // response path gating
  input  logic                         m_rsp_valid,
  input  logic                         emit,
  input  logic                         sa_rsp_ready,
  output logic                         m_rsp_ready,
  output logic                         sa_rsp_valid,
  // status for the realign blocks
  output align_pkg::req_rec_t          cur,
  output align_pkg::beat_cnt_t         cmd_beat,
  output align_pkg::beat_cnt_t         rsp_beat,
  output logic                         w_take,
  output logic                         cmd_fire,
  output logic                         rsp_fire
);
  import icb_pkg::*;
  import align_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_drain
  } state_t;

  state_t     state;
  state_t     state_nxt;
  beat_cnt_t  last_idx;
  logic       busy;
  logic       need_w;
  logic       cmd_last;
  logic       rsp_last;
  addr_view_u pop_view;
  addr_view_u m_view;

  // ========================================
  // command side
  // ========================================
  assign busy     = (state != st_idle);
  assign last_idx = last_beat(cur);
  assign need_w   = w_beat_needed(cur, cmd_beat);

  // registered state and pointers only
  assign q_pop = (state == st_idle) && !q_empty;

  // extra unaligned write beat runs off the carry buffer
  assign m_cmd_valid = (state == st_issue) && (!need_w || sa_w_valid);
  // upstream write beat moves only together with its downstream beat
  assign sa_w_ready  = (state == st_issue) && need_w && m_cmd_ready;
  assign cmd_fire    = m_cmd_valid && m_cmd_ready;
  assign w_take      = sa_w_valid && sa_w_ready;
  assign cmd_last    = cmd_fire && (cmd_beat == last_idx);

  // word view of the base plus beat index, offset forced to zero
  always_comb begin
    m_view.w.word = cur.addr.w.word + (addr_w-2)'(cmd_beat);
    m_view.w.off  = '0;
  end
  assign m_addr = m_view.byte_addr;

  // ========================================
  // response side
  // ========================================
  // absorbed beats are taken at once, emitted ones follow upstream
  assign sa_rsp_valid = busy && m_rsp_valid && emit;
  assign m_rsp_ready  = busy && (emit ? sa_rsp_ready : 1'b1);
  assign rsp_fire     = m_rsp_valid && m_rsp_ready;
  assign rsp_last     = rsp_fire && (rsp_beat == last_idx);

  // ========================================
  // FSM
  // ========================================
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (q_pop) begin
          state_nxt = st_issue;
        end
      end
      st_issue: begin
        // last response can share the cycle with the last command
        if (rsp_last) begin
          state_nxt = st_idle;
        end else if (cmd_last) begin
          state_nxt = st_drain;
        end
      end
      st_drain: begin
        if (rsp_last) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  assign pop_view.byte_addr = q_head.addr;

  // state, request latch and both beat counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      cur      <= '0;
      cmd_beat <= '0;
      rsp_beat <= '0;
    end else begin
      state <= state_nxt;
      if (q_pop) begin
        cur.read    <= q_head.read;
        cur.addr    <= pop_view;
        cur.len     <= q_head.len;
        cur.crosses <= (pop_view.w.off != '0);
        cmd_beat    <= '0;
        rsp_beat    <= '0;
      end else begin
        if (cmd_fire) begin
          cmd_beat <= cmd_beat + 1'b1;
        end
        if (rsp_fire) begin
          rsp_beat <= rsp_beat + 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/cmd_queue.sv ====
// outstanding request FIFO between the upstream command port and the controller
// head is read combinationally, pop advances to the next entry

`timescale 1ns/100ps

module cmd_queue #(
  parameter int outs_depth = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  icb_pkg::icb_cmd_t push_cmd,
  input  logic              pop,
  output icb_pkg::icb_cmd_t head,
  output logic              full,
  output logic              empty
);
  import icb_pkg::*;

  localparam int ptr_w = $clog2(outs_depth);

  // extra msb tells full from empty
  logic [ptr_w:0] wr_ptr;
  logic [ptr_w:0] rd_ptr;
  icb_cmd_t       mem [outs_depth];

  // ========================================
  // flags
  // ========================================
  assign empty = (wr_ptr == rd_ptr);
  // same slot, wrapped a different number of times
  assign full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                 (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

  // pointer update
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[ptr_w-1:0]] <= push_cmd;
    end
  end

  // unregistered head
  assign head = mem[rd_ptr[ptr_w-1:0]];

endmodule

// ==== design/align_pkg.sv ====
// address views and request record shared by the control and realign blocks
// also the burst length rules that the controller and both realign paths follow

package align_pkg;

  // byte offset inside a 32-bit word
  typedef logic [1:0] offset_t;

  // beat index, one bit wider than len so len+2 beats fit
  typedef logic [icb_pkg::len_w:0] beat_cnt_t;

  // word index plus byte offset
  typedef struct packed {
    logic [icb_pkg::addr_w-3:0] word;
    offset_t                    off;
  } word_view_t;

  // one address, seen as bytes or as word/offset
  typedef union packed {
    logic [icb_pkg::addr_w-1:0] byte_addr;
    word_view_t                 w;
  } addr_view_u;

  // request held by the controller for the whole burst
  typedef struct packed {
    logic                      read;
    addr_view_u                addr;
    logic [icb_pkg::len_w-1:0] len;
    // offset non-zero, one extra downstream beat
    logic                      crosses;
  } req_rec_t;

  // index of the final downstream beat, len + crosses
  function automatic beat_cnt_t last_beat(req_rec_t rec);
    return beat_cnt_t'(rec.len) + beat_cnt_t'(rec.crosses);
  endfunction

  // write beat k <= len consumes upstream beat k
  function automatic logic w_beat_needed(req_rec_t rec, beat_cnt_t beat);
    return !rec.read && (beat <= beat_cnt_t'(rec.len));
  endfunction

endpackage

// ==== design/icb_pkg.sv ====
// bus widths and beat records for the upstream and downstream ports
// import where a port payload is built or taken apart

package icb_pkg;

  // ========================================
  // fixed bus widths
  // ========================================
  localparam int addr_w  = 32;
  localparam int data_w  = 32;
  // burst len field, beat count minus one
  localparam int len_w   = 3;
  localparam int bytes_w = 4;

  // ========================================
  // channel payloads
  // ========================================

  // upstream command, byte address may be unaligned
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              read;
    logic [len_w-1:0]  len;
  } icb_cmd_t;

  // one upstream write beat
  typedef struct packed {
    logic [data_w-1:0]  wdata;
    logic [bytes_w-1:0] wmask;
  } icb_wbeat_t;

  // downstream command, addr always word aligned
  typedef struct packed {
    logic [addr_w-1:0]  addr;
    logic               read;
    logic [data_w-1:0]  wdata;
    logic [bytes_w-1:0] wmask;
  } icb_mcmd_t;

  // response, same shape on both sides
  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
  } icb_rsp_t;

endpackage
